// File: bench/cpu_cases.txt
# tags: c name | p count words (program from word 0) | d addr count words (data preload)
# r r0..r7 | f flags | m word_addr word (expected) | e runs the case | all numbers hex
c alu_ops
p 15 1000 0005 1200 0007 2041 1400 0003 2080 1600 00ff 1800 0f0f 2702 1a00 1200 2b03 1c00 1f0f 2d44 2445 7000
r 00000001 00000007 00000003 0000000f 00000f0f 00001f0f 00000000 00000000
f 01
e
c cmp_equal
p 6 1e00 4242 1c00 4242 2f85 7000
r 0 0 0 0 0 0 00004242 00004242
f 40
e
c mem_indexed
p f 1200 0204 3440 00fc 1600 00f0 44e0 0010 3860 0000 48c0 0010 3260 0000 7000
d 0100 6 5678 1234 beef dead 0001 0000
r 0 00000001 12345678 000000f4 deadbeef 0 0 0
f 00
m 0080 5678
m 0081 1234
m 0082 beef
m 0083 dead
e
c jr_cond
p 23 1200 0001 1400 0001 2285 5001 0004 1e00 0bad 5002 0004 1600 0011 5003 0004 1800 0022 24c5 5003 0004 1e00 0bad 5002 0004 1e00 0bad 5001 0004 1a00 0033 5000 0004 1e00 0bad 7000
r 0 00000001 00000001 00000011 00000022 00000033 0 0
f 01
e
c djnz_loop
p 8 1200 0005 1600 0003 24c0 6200 fffa 7000
r 0 0 0000000f 00000003 0 0 0 0
f 00
e

// File: bench/cpu_mem_model.sv
// cpu_mem_model
// Behavioral 64K-word memory on the four-phase req/ack bus. The ack delay
// for each request comes from the testbench. Backdoor fill, load and peek.

`timescale 1ns/1ps

module cpu_mem_model import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    output logic        ack,
    input  logic        we,
    input  logic [15:0] addr,
    input  bus_word_t   wdata,
    output bus_word_t   rdata,
    input  logic [2:0]  ack_delay,   // cycles before ack, taken at request
    output logic        stuck        // req held too long after ack
);

    localparam int HOLD_LIMIT = 1000;

    typedef enum logic [1:0] {M_IDLE, M_DELAY, M_ACK} mstate_t;

    bus_word_t  mem [65536];
    mstate_t    state;
    logic [2:0] cnt;
    int         hold;

    always @(posedge clk) begin
        if (!rst_n) begin
            state <= M_IDLE;
            ack   <= 1'b0;
            rdata <= '0;
            stuck <= 1'b0;
            hold  <= 0;
        end else begin
            case (state)
                M_IDLE: if (req) begin
                    cnt   <= ack_delay;
                    state <= M_DELAY;
                end
                M_DELAY: if (cnt == 3'd0) begin
                    ack  <= 1'b1;
                    hold <= 0;
                    if (we) mem[addr] <= wdata;
                    else    rdata     <= mem[addr];   // held while ack is high
                    state <= M_ACK;
                end else begin
                    cnt <= cnt - 3'd1;
                end
                default: begin   // M_ACK, wait for req to drop
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= M_IDLE;
                    end else if (hold == HOLD_LIMIT) begin
                        stuck <= 1'b1;
                    end else begin
                        hold <= hold + 1;
                    end
                end
            endcase
        end
    end

    task automatic fill_pattern();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = bus_word_t'(i) ^ 16'h5a3c;
        end
    endtask

    task automatic load_word(input logic [15:0] a, input bus_word_t d);
        mem[a] = d;
    endtask

    function automatic bus_word_t peek_word(input logic [15:0] a);
        return mem[a];
    endfunction

endmodule

// File: bench/cpu_tb.sv
// cpu_tb
// Testbench for cpu_core. Reads programs and expected results from the
// cases file, runs each case with zero delay and again with random ack
// delays and cen gaps, then checks registers, flags and memory.

`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*;;

    localparam int RESET_CYCLES = 10;
    localparam int RUN_LIMIT    = 20000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cen;
    logic        ram_req, ram_ack, ram_we;
    logic [15:0] ram_addr;
    bus_word_t   ram_wdata, ram_rdata;
    logic        halted;
    dump_sel_t   dmp_addr;
    logic [7:0]  dmp_dout;
    logic [2:0]  ack_delay;
    logic        stuck;

    logic [31:0] rnd = 32'hcf55_adf6;
    int          fd;
    string       name;
    bus_word_t   prog[$];
    logic [15:0] pre_addr[$];
    bus_word_t   pre_data[$];
    reg_word_t   exp_regs [8];
    flags_t      exp_flags;
    logic [15:0] exp_mem_addr[$];
    bus_word_t   exp_mem_data[$];

    always #2 clk = ~clk;

    cpu_core #(.MEM_AW(16)) cpu_core_i (
        .clk(clk), .rst_n(rst_n), .cen(cen),
        .ram_req(ram_req), .ram_ack(ram_ack), .ram_we(ram_we),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata),
        .halted(halted), .dmp_addr(dmp_addr), .dmp_dout(dmp_dout)
    );

    cpu_mem_model mem_i (
        .clk(clk), .rst_n(rst_n), .req(ram_req), .ack(ram_ack), .we(ram_we),
        .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata),
        .ack_delay(ack_delay), .stuck(stuck)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_reg(input string test, input int idx, input reg_word_t exp,
                             input reg_word_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s r%0d expected %h actual %h", test, idx, exp, act));
        end
    endtask

    task automatic check_flags(input string test, input flags_t exp, input flags_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s flags expected %h actual %h", test, exp, act));
        end
    endtask

    task automatic check_mem(input string test, input logic [15:0] a, input bus_word_t exp,
                             input bus_word_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s mem[%h] expected %h actual %h",
                                test, a, exp, act));
        end
    endtask

    task automatic read_hex(output logic [31:0] v);
        int code;
        code = $fscanf(fd, "%h", v);
        if (code != 1) abort_run("malformed number in the cases file");
    endtask

    // dump is combinational, so drive on the edge and sample mid-cycle
    task automatic read_dump(input dump_sel_t sel, output logic [7:0] val);
        @(posedge clk);
        dmp_addr <= sel;
        @(negedge clk);
        val = dmp_dout;
    endtask

    task automatic read_reg(input int r, output reg_word_t val);
        logic [7:0] b;
        for (int i = 0; i < 4; i++) begin
            read_dump(dump_sel_t'(r * 4 + i), b);   // little-endian bytes
            val[i*8 +: 8] = b;
        end
    endtask

    task automatic check_dump(input string test, input bit expect_zero);
        reg_word_t  val;
        logic [7:0] f;
        for (int i = 0; i < 8; i++) begin
            read_reg(i, val);
            check_reg(test, i, expect_zero ? reg_word_t'(0) : exp_regs[i], val);
        end
        read_dump(DUMP_FLAGS, f);
        check_flags(test, expect_zero ? flags_t'(0) : exp_flags, flags_t'(f));
    endtask

    task automatic run_case(input bit slow);
        string test;
        int    cycles;
        if (slow) test = {name, "/random"};
        else      test = {name, "/nodelay"};
        @(posedge clk);
        rst_n     <= 1'b0;
        cen       <= 1'b1;
        ack_delay <= 3'd0;
        @(negedge clk);
        mem_i.fill_pattern();
        foreach (prog[i]) mem_i.load_word(16'(i), prog[i]);   // program at word 0
        foreach (pre_addr[i]) mem_i.load_word(pre_addr[i], pre_data[i]);
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        cen   <= 1'b0;   // core holds its reset state during the dump
        check_dump({test, " reset"}, 1'b1);
        if (ram_req || ram_we || halted) begin
            abort_run({test, ": ram_req, ram_we or halted high after reset"});
        end
        @(posedge clk);
        cen <= 1'b1;
        @(posedge clk);   // first edge with rst_n and cen high
        @(negedge clk);
        if (ram_req) abort_run({test, ": ram_req rose too early after start"});
        @(posedge clk);
        @(negedge clk);
        if (!ram_req) abort_run({test, ": no memory request one cycle after start"});
        cycles = 0;
        while (!halted && cycles < RUN_LIMIT) begin
            @(posedge clk);
            if (slow) begin
                rnd = xorshift32(rnd);
                cen       <= (rnd[1:0] != 2'b00);   // low about a quarter of the time
                ack_delay <= 3'(rnd[15:8] % 6);
            end
            @(negedge clk);
            if (stuck) abort_run({test, ": memory handshake stalled"});
            cycles++;
        end
        if (!halted) abort_run({test, ": timeout waiting for halted"});
        @(posedge clk);
        cen       <= 1'b1;
        ack_delay <= 3'd0;
        check_dump(test, 1'b0);
        if (!halted) abort_run({test, ": halted dropped after HALT"});
        foreach (exp_mem_addr[i]) begin
            check_mem(test, exp_mem_addr[i], exp_mem_data[i],
                      mem_i.peek_word(exp_mem_addr[i]));
        end
    endtask

    initial begin
        string            tag;
        logic [31:0]      n;
        logic [31:0]      a;
        logic [31:0]      w;
        int               code;
        logic [8*256-1:0] line;
        rst_n     = 1'b0;
        cen       = 1'b0;
        dmp_addr  = '0;
        ack_delay = 3'd0;
        fd = $fopen("bench/cpu_cases.txt", "r");
        if (fd == 0) abort_run("could not open bench/cpu_cases.txt");
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(line, fd);   // rest of a comment line
            end else if (tag == "c") begin
                code = $fscanf(fd, "%s", name);
                prog.delete();
                pre_addr.delete();
                pre_data.delete();
                exp_mem_addr.delete();
                exp_mem_data.delete();
            end else if (tag == "p") begin
                read_hex(n);
                repeat (n) begin
                    read_hex(w);
                    prog.push_back(w[15:0]);
                end
            end else if (tag == "d") begin
                read_hex(a);
                read_hex(n);
                for (int i = 0; i < n; i++) begin
                    read_hex(w);
                    pre_addr.push_back(a[15:0] + 16'(i));
                    pre_data.push_back(w[15:0]);
                end
            end else if (tag == "r") begin
                for (int i = 0; i < 8; i++) read_hex(exp_regs[i]);
            end else if (tag == "f") begin
                read_hex(w);
                exp_flags = w[7:0];
            end else if (tag == "m") begin
                read_hex(a);
                read_hex(w);
                exp_mem_addr.push_back(a[15:0]);
                exp_mem_data.push_back(w[15:0]);
            end else if (tag == "e") begin
                run_case(1'b0);
                run_case(1'b1);
            end else begin
                abort_run({"unknown tag in the cases file: ", tag});
            end
        end
        $fclose(fd);
        $display("No errors");
        $finish;
    end

endmodule

// File: build.f
design/cpu_pkg.sv
design/cpu_regs.sv
design/cpu_alu.sv
design/cpu_idxaddr.sv
design/cpu_ctrl.sv
design/cpu_ramctl.sv
design/cpu_core.sv
bench/cpu_mem_model.sv
bench/cpu_tb.sv

// File: design/cpu_alu.sv
// cpu_alu
// 32-bit ALU with the Z and C flags. Results and flags are registered one
// cycle after the enable. Also runs the DJNZ decrement and its zero test,
// which leave the flags alone.

`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,

    input  logic       alu_en,
    input  alu_op_t    alu_op,
    input  reg_word_t  op_a,
    input  reg_word_t  op_b,
    input  logic       djnz_en,

    output reg_word_t  alu_out,
    output flags_t     flags,
    output logic       djnz_zero,

    input  dump_sel_t  dmp_addr,
    output logic [7:0] dmp_flags
);

    reg_word_t res;
    reg_word_t dec;
    logic      carry;
    flags_t    new_flags;

    always_comb begin
        carry = 1'b0;
        case (alu_op)
            ALU_ADD:          {carry, res} = {1'b0, op_a} + {1'b0, op_b};
            ALU_SUB, ALU_CMP: {carry, res} = {1'b0, op_a} - {1'b0, op_b};  // borrow in bit 32
            ALU_AND:          res = op_a & op_b;
            ALU_OR:           res = op_a | op_b;
            ALU_XOR:          res = op_a ^ op_b;
            default:          res = op_b;
        endcase
        new_flags         = '0;
        new_flags[FLAG_Z] = (res == '0);
        new_flags[FLAG_C] = carry;
    end

    assign dec = op_a - 32'd1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_out   <= '0;
            flags     <= '0;
            djnz_zero <= 1'b0;
        end else if (cen) begin
            if (alu_en) begin
                alu_out <= res;    // CMP result is never written back
                flags   <= new_flags;
            end
            if (djnz_en) begin
                alu_out   <= dec;
                djnz_zero <= (dec == '0);
            end
        end
    end

    assign dmp_flags = (dmp_addr == DUMP_FLAGS) ? flags : 8'h00;

endmodule

// File: design/cpu_core.sv
// cpu_core
// Top level of the processor core: control unit, register bank, ALU,
// indexed addresser and memory controller, plus the write-back and dump
// muxes.

`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; #(
    parameter int MEM_AW = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,

    output logic              ram_req,
    input  logic              ram_ack,
    output logic              ram_we,
    output logic [MEM_AW-1:0] ram_addr,
    output bus_word_t         ram_wdata,
    input  bus_word_t         ram_rdata,

    output logic              halted,

    input  dump_sel_t         dmp_addr,
    output logic [7:0]        dmp_dout
);

    // memory controller
    logic       mem_start, mem_write, mem_long, mem_done;
    addr_t      mem_addr;
    reg_word_t  mem_rdata;

    // register bank
    reg_sel_t   rd_a, rd_b, wr_sel;
    reg_word_t  a_out, b_out, wr_data, imm;
    logic       wr_en, post_inc;
    wr_src_t    wr_src;
    logic [7:0] dmp_byte;

    // ALU
    alu_op_t    alu_op;
    logic       alu_en, djnz_en, djnz_zero;
    reg_word_t  alu_out;
    flags_t     flags;
    logic [7:0] dmp_flags;

    // addresser
    logic       idx_load;
    logic [7:0] disp;
    addr_t      ea;

    always_comb begin
        case (wr_src)
            WR_IMM:  wr_data = imm;
            WR_MEM:  wr_data = mem_rdata;
            default: wr_data = alu_out;
        endcase
    end

    assign dmp_dout = (dmp_addr == DUMP_FLAGS) ? dmp_flags : dmp_byte;

    cpu_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .cen(cen),
        .mem_start(mem_start), .mem_write(mem_write), .mem_long(mem_long),
        .mem_addr(mem_addr), .mem_done(mem_done), .mem_rdata(mem_rdata),
        .rd_a(rd_a), .rd_b(rd_b), .wr_en(wr_en), .wr_sel(wr_sel),
        .wr_src(wr_src), .imm(imm), .post_inc(post_inc),
        .alu_op(alu_op), .alu_en(alu_en), .djnz_en(djnz_en),
        .djnz_zero(djnz_zero), .flags(flags),
        .idx_load(idx_load), .disp(disp), .ea(ea),
        .halted(halted)
    );

    cpu_regs u_regs (
        .clk(clk), .rst_n(rst_n), .cen(cen),
        .rd_a(rd_a), .rd_b(rd_b), .a_out(a_out), .b_out(b_out),
        .wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data),
        .post_inc(post_inc), .post_sel(rd_a),   // index register is on port a
        .dmp_addr(dmp_addr), .dmp_byte(dmp_byte)
    );

    cpu_alu u_alu (
        .clk(clk), .rst_n(rst_n), .cen(cen),
        .alu_en(alu_en), .alu_op(alu_op), .op_a(a_out), .op_b(b_out),
        .djnz_en(djnz_en), .alu_out(alu_out), .flags(flags),
        .djnz_zero(djnz_zero), .dmp_addr(dmp_addr), .dmp_flags(dmp_flags)
    );

    cpu_idxaddr u_idxaddr (
        .clk(clk), .rst_n(rst_n), .cen(cen),
        .idx_load(idx_load), .base(a_out), .disp(disp), .ea(ea)
    );

    cpu_ramctl #(.MEM_AW(MEM_AW)) u_ramctl (
        .clk(clk), .rst_n(rst_n), .cen(cen),
        .mem_start(mem_start), .mem_write(mem_write), .mem_long(mem_long),
        .mem_addr(mem_addr), .mem_wdata(b_out),   // store data from port b
        .mem_done(mem_done), .mem_rdata(mem_rdata),
        .ram_req(ram_req), .ram_ack(ram_ack), .ram_we(ram_we),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
    );

endmodule

// File: design/cpu_ctrl.sv
// cpu_ctrl
// Fetch, decode and execute FSM. Holds the instruction register, the
// operand word and the PC, resolves JR and DJNZ branches and drives all
// datapath controls. One memory request is in flight at a time.

`timescale 1ns/1ps

module cpu_ctrl import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,

    // memory controller
    output logic       mem_start,
    output logic       mem_write,
    output logic       mem_long,
    output addr_t      mem_addr,
    input  logic       mem_done,
    input  reg_word_t  mem_rdata,

    // register bank
    output reg_sel_t   rd_a,
    output reg_sel_t   rd_b,
    output logic       wr_en,
    output reg_sel_t   wr_sel,
    output wr_src_t    wr_src,
    output reg_word_t  imm,
    output logic       post_inc,

    // ALU
    output alu_op_t    alu_op,
    output logic       alu_en,
    output logic       djnz_en,
    input  logic       djnz_zero,
    input  flags_t     flags,

    // addresser
    output logic       idx_load,
    output logic [7:0] disp,
    input  addr_t      ea,

    output logic       halted
);

    typedef enum logic [2:0] {
        S_FETCH, S_FETCH2, S_EXEC, S_ADDR, S_MEM, S_WB, S_HALT
    } state_t;

    state_t    state;
    bus_word_t ir;
    bus_word_t op2;        // second instruction word
    addr_t     pc;
    logic      pend;       // request issued, waiting for mem_done
    opcode_t   opc;
    opcode_t   new_opc;
    addr_t     disp_ext;
    logic      jr_taken;

    assign opc      = opcode_t'(ir[15:12]);
    assign new_opc  = opcode_t'(mem_rdata[15:12]);   // word arriving now
    assign disp_ext = {{16{op2[7]}}, op2[7:0]};

    always_comb begin
        case (cond_t'(ir[1:0]))
            COND_Z:  jr_taken = flags[FLAG_Z];
            COND_NZ: jr_taken = !flags[FLAG_Z];
            COND_C:  jr_taken = flags[FLAG_C];
            default: jr_taken = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_FETCH;
            pc        <= RESET_PC;
            pend      <= 1'b0;
            mem_start <= 1'b0;
            mem_write <= 1'b0;
            mem_long  <= 1'b0;
            mem_addr  <= RESET_PC;
            ir        <= '0;
            op2       <= '0;
        end else if (cen) begin
            mem_start <= 1'b0;
            case (state)
                S_FETCH, S_FETCH2: begin
                    if (!pend) begin
                        mem_start <= 1'b1;
                        pend      <= 1'b1;
                        mem_write <= 1'b0;
                        mem_long  <= 1'b0;
                        mem_addr  <= pc;
                    end else if (mem_done) begin
                        pend <= 1'b0;
                        pc   <= pc + 24'd2;
                        if (state == S_FETCH) begin
                            ir <= mem_rdata[15:0];
                            case (new_opc)
                                OP_LDI, OP_LD, OP_ST, OP_JR, OP_DJNZ: state <= S_FETCH2;
                                OP_ALU:  state <= S_EXEC;
                                OP_HALT: state <= S_HALT;
                                default: state <= S_FETCH;   // NOP and unused codes
                            endcase
                        end else begin
                            op2 <= mem_rdata[15:0];
                            case (opc)
                                OP_LDI:       state <= S_WB;
                                OP_LD, OP_ST: state <= S_ADDR;
                                default:      state <= S_EXEC;
                            endcase
                        end
                    end
                end
                S_ADDR: state <= S_MEM;   // ea registered here
                S_MEM: begin
                    if (!pend) begin
                        mem_start <= 1'b1;
                        pend      <= 1'b1;
                        mem_write <= (opc == OP_ST);
                        mem_long  <= 1'b1;
                        mem_addr  <= ea;
                    end else if (mem_done) begin
                        pend  <= 1'b0;
                        state <= S_WB;
                    end
                end
                S_EXEC: begin
                    if (opc == OP_JR) begin
                        if (jr_taken) begin
                            pc <= pc + disp_ext;
                        end
                        state <= S_FETCH;
                    end else begin
                        state <= S_WB;
                    end
                end
                S_WB: begin
                    if (opc == OP_DJNZ && !djnz_zero) begin
                        pc <= pc + disp_ext;   // loop back
                    end
                    state <= S_FETCH;
                end
                default: state <= S_HALT;
            endcase
        end
    end

    // operand selection depends only on the instruction
    assign rd_a   = (opc == OP_ALU || opc == OP_DJNZ) ? ir[11:9] : ir[8:6];
    assign rd_b   = (opc == OP_ALU) ? ir[8:6] : ir[11:9];
    assign wr_sel = ir[11:9];
    assign wr_src = (opc == OP_LDI) ? WR_IMM : (opc == OP_LD) ? WR_MEM : WR_ALU;
    assign imm    = {16'h0000, op2};
    assign alu_op = alu_op_t'(ir[2:0]);
    assign disp   = op2[7:0];

    assign wr_en    = (state == S_WB) &&
                      (opc == OP_LDI || opc == OP_LD || opc == OP_DJNZ ||
                       (opc == OP_ALU && alu_op != ALU_CMP));
    assign post_inc = (state == S_WB) && (opc == OP_LD || opc == OP_ST) && ir[5];
    assign alu_en   = (state == S_EXEC) && (opc == OP_ALU);
    assign djnz_en  = (state == S_EXEC) && (opc == OP_DJNZ);
    assign idx_load = (state == S_ADDR);
    assign halted   = (state == S_HALT);

endmodule

// File: design/cpu_idxaddr.sv
// cpu_idxaddr
// Indexed effective address: base register plus the sign-extended 8-bit
// displacement, wrapping at 24 bits and registered on idx_load.

`timescale 1ns/1ps

module cpu_idxaddr import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,

    input  logic       idx_load,
    input  reg_word_t  base,
    input  logic [7:0] disp,
    output addr_t      ea
);

    addr_t disp_ext;

    assign disp_ext = {{16{disp[7]}}, disp};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ea <= '0;
        end else if (cen && idx_load) begin
            ea <= base[23:0] + disp_ext;   // wraps naturally at 24 bits
        end
    end

endmodule

// File: design/cpu_pkg.sv
// cpu_pkg
// Shared types, opcode and ALU encodings, flag positions and the reset
// vector for the 16-bit bus, 32-bit register processor core.

package cpu_pkg;

    typedef logic [23:0] addr_t;       // byte address, bit 0 dropped on the bus
    typedef logic [15:0] bus_word_t;   // memory and instruction word
    typedef logic [31:0] reg_word_t;   // register and ALU value
    typedef logic [ 2:0] reg_sel_t;    // register number
    typedef logic [ 7:0] flags_t;      // only Z and C are used
    typedef logic [ 5:0] dump_sel_t;   // 0-31 register bytes, 32 flags

    // instruction class, bits 15:12 of the first word
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_LDI  = 4'd1,
        OP_ALU  = 4'd2,
        OP_LD   = 4'd3,
        OP_ST   = 4'd4,
        OP_JR   = 4'd5,
        OP_DJNZ = 4'd6,
        OP_HALT = 4'd7
    } opcode_t;

    // ALU operation, bits 2:0 of an ALU instruction
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_CMP = 3'd5
    } alu_op_t;

    // jump condition, bits 1:0 of a JR instruction
    typedef enum logic [1:0] {
        COND_ALWAYS = 2'd0,
        COND_Z      = 2'd1,
        COND_NZ     = 2'd2,
        COND_C      = 2'd3
    } cond_t;

    // register write-back source
    typedef enum logic [1:0] {
        WR_IMM = 2'd0,
        WR_ALU = 2'd1,
        WR_MEM = 2'd2
    } wr_src_t;

    localparam int FLAG_Z = 6;
    localparam int FLAG_C = 0;

    localparam reg_word_t POST_INC_STEP = 32'd4;   // one 32-bit datum
    localparam dump_sel_t DUMP_FLAGS    = 6'd32;
    localparam addr_t     RESET_PC      = 24'h00_0000;

endpackage

// File: design/cpu_ramctl.sv
// cpu_ramctl
// Memory controller on a four-phase req/ack bus. A 32-bit access becomes
// two 16-bit transfers, low half first at the word address, high half at
// the next word. Read halves are assembled into mem_rdata.

`timescale 1ns/1ps

module cpu_ramctl import cpu_pkg::*; #(
    parameter int MEM_AW = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,

    input  logic              mem_start,
    input  logic              mem_write,
    input  logic              mem_long,
    input  addr_t             mem_addr,
    input  reg_word_t         mem_wdata,
    output logic              mem_done,
    output reg_word_t         mem_rdata,

    output logic              ram_req,
    input  logic              ram_ack,
    output logic              ram_we,
    output logic [MEM_AW-1:0] ram_addr,
    output bus_word_t         ram_wdata,
    input  bus_word_t         ram_rdata
);

    typedef enum logic [1:0] {IDLE, REQ, RELEASE, NEXT} state_t;

    state_t    state;
    logic      long_q;
    logic      half;       // high half in progress
    bus_word_t wdata_hi;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            ram_req  <= 1'b0;
            ram_we   <= 1'b0;
            mem_done <= 1'b0;
            long_q   <= 1'b0;
            half     <= 1'b0;
        end else if (cen) begin
            mem_done <= 1'b0;
            case (state)
                IDLE: if (mem_start) begin
                    ram_req   <= 1'b1;
                    ram_we    <= mem_write;
                    ram_addr  <= MEM_AW'(mem_addr[23:1]);
                    ram_wdata <= mem_wdata[15:0];
                    wdata_hi  <= mem_wdata[31:16];
                    long_q    <= mem_long;
                    half      <= 1'b0;
                    state     <= REQ;
                end
                REQ: if (ram_ack) begin
                    if (!ram_we) begin
                        if (half) mem_rdata[31:16] <= ram_rdata;
                        else      mem_rdata[15:0]  <= ram_rdata;
                    end
                    ram_req <= 1'b0;
                    state   <= RELEASE;
                end
                RELEASE: if (!ram_ack) begin
                    if (long_q && !half) begin
                        state <= NEXT;
                    end else begin
                        ram_we   <= 1'b0;
                        mem_done <= 1'b1;
                        state    <= IDLE;
                    end
                end
                default: begin   // NEXT, start the high half
                    ram_req   <= 1'b1;
                    ram_addr  <= ram_addr + 1'b1;
                    ram_wdata <= wdata_hi;
                    half      <= 1'b1;
                    state     <= REQ;
                end
            endcase
        end
    end

endmodule

// File: design/cpu_regs.sv
// cpu_regs
// Eight 32-bit general registers. Two combinational read ports, one write
// port and a post-increment of the index register on the same edge.
// Also drives one byte of the register file onto the dump port.

`timescale 1ns/1ps

module cpu_regs import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cen,

    input  reg_sel_t  rd_a,
    input  reg_sel_t  rd_b,
    output reg_word_t a_out,
    output reg_word_t b_out,

    input  logic      wr_en,
    input  reg_sel_t  wr_sel,
    input  reg_word_t wr_data,

    input  logic      post_inc,
    input  reg_sel_t  post_sel,

    input  dump_sel_t dmp_addr,
    output logic [7:0] dmp_byte
);

    reg_word_t regs [8];
    reg_word_t dmp_reg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (cen) begin
            if (post_inc) begin
                regs[post_sel] <= regs[post_sel] + POST_INC_STEP;
            end
            // later assignment, so a load into the index register wins
            if (wr_en) begin
                regs[wr_sel] <= wr_data;
            end
        end
    end

    assign a_out = regs[rd_a];
    assign b_out = regs[rd_b];

    // little-endian byte select, register number in bits 4:2
    assign dmp_reg  = regs[dmp_addr[4:2]];
    assign dmp_byte = dmp_reg[dmp_addr[1:0]*8 +: 8];

endmodule
